//--- soc_bus_pkg.sv
// Wishbone and CSR bus widths, CSR address fields and bridge states
`default_nettype none

package soc_bus_pkg;

	// --------------------------------------------------------------------
	// Widths
	// --------------------------------------------------------------------
	// Byte address on the Wishbone side
	localparam int unsigned WB_ADDR_W = 32;
	// Shared by Wishbone and CSR data paths
	localparam int unsigned WB_DATA_W = 32;
	// CSR word address
	localparam int unsigned CSR_ADDR_W = 15;
	localparam int unsigned CSR_BANK_W = 5;
	localparam int unsigned CSR_REG_W = 10;

	// --------------------------------------------------------------------
	// Field positions
	// --------------------------------------------------------------------
	// Word address inside the byte address, bits 16 to 2
	localparam int unsigned CSR_ADDR_LSB = 2;
	localparam int unsigned CSR_ADDR_MSB = CSR_ADDR_LSB + CSR_ADDR_W - 1;
	// Register index in the low bits of the CSR address
	localparam int unsigned CSR_REG_LSB = 0;
	localparam int unsigned CSR_REG_MSB = CSR_REG_LSB + CSR_REG_W - 1;
	// Bank number above it
	localparam int unsigned CSR_BANK_LSB = CSR_REG_MSB + 1;
	localparam int unsigned CSR_BANK_MSB = CSR_ADDR_W - 1;

	// --------------------------------------------------------------------
	// Bridge timing and states
	// --------------------------------------------------------------------
	// Sampling edge to acknowledge
	localparam int unsigned WB_ACK_DELAY = 3;
	// One strobe cycle plus this many wait cycles
	localparam int unsigned WB_WAIT_CYCLES = WB_ACK_DELAY - 2;
	localparam int unsigned WB_WAIT_W = $clog2(WB_ACK_DELAY);

	localparam int unsigned BRG_STATE_W = 2;
	localparam logic [BRG_STATE_W-1:0] BRG_IDLE = 2'd0;
	localparam logic [BRG_STATE_W-1:0] BRG_STROBE = 2'd1;
	localparam logic [BRG_STATE_W-1:0] BRG_WAIT = 2'd2;
	localparam logic [BRG_STATE_W-1:0] BRG_ACK = 2'd3;

endpackage

`default_nettype wire

//--- soc_periph_pkg.sv
// Peripheral bank numbers, register indices, control bits and reset hold length
`default_nettype none

package soc_periph_pkg;

	// --------------------------------------------------------------------
	// Banks
	// --------------------------------------------------------------------
	// Timer k sits in bank k
	localparam int unsigned NUM_TIMERS = 4;
	// Interrupt controller right above the timers
	localparam int unsigned IRQ_BANK = 4;

	// --------------------------------------------------------------------
	// Timer registers
	// --------------------------------------------------------------------
	localparam int unsigned TIMER_REG_CTRL = 0;
	localparam int unsigned TIMER_REG_COMPARE = 1;
	localparam int unsigned TIMER_REG_COUNTER = 2;
	// Control bits
	localparam int unsigned TIMER_CTRL_EN_BIT = 0;
	localparam int unsigned TIMER_CTRL_AR_BIT = 1;

	// Interrupt controller registers
	localparam int unsigned IRQ_REG_PENDING = 0;
	localparam int unsigned IRQ_REG_MASK = 1;

	// --------------------------------------------------------------------
	// Reset stretch
	// --------------------------------------------------------------------
	// Cycles of system reset after the trigger goes low
	localparam int unsigned RST_HOLD_CYCLES = 16;
	// Hold counter must reach RST_HOLD_CYCLES
	localparam int unsigned RST_CNT_W = $clog2(RST_HOLD_CYCLES + 1);

endpackage

`default_nettype wire

//--- reset_gen.sv
// Reset generator stretching the reset trigger into the system reset
`timescale 1ns/100ps
`default_nettype none

module reset_gen
	import soc_periph_pkg::*;
(
	input  logic sys_clk,
	input  logic trigger_reset,
	output logic sys_rst
);

	// --------------------------------------------------------------------
	// Hold counter
	// --------------------------------------------------------------------
	logic [RST_CNT_W-1:0] hold_cnt;
	logic                 hold_active;

	// Still counting down
	assign hold_active = (hold_cnt != '0);

	// Reload while triggered
	// Then count down one per cycle until empty
	always_ff @(posedge sys_clk) begin
		if (trigger_reset) begin
			hold_cnt <= RST_CNT_W'(RST_HOLD_CYCLES);
		end else if (hold_active) begin
			hold_cnt <= hold_cnt - 1'b1;
		end
	end

	// --------------------------------------------------------------------
	// Registered system reset
	// --------------------------------------------------------------------
	// Old counter value is used here
	// so the release lands RST_HOLD_CYCLES edges after the trigger drops
	always_ff @(posedge sys_clk) begin
		sys_rst <= trigger_reset | hold_active;
	end

endmodule

`default_nettype wire

//--- wb_csr_bridge.sv
// Wishbone classic slave to CSR bus bridge, one CSR cycle per access
`timescale 1ns/100ps
`default_nettype none

module wb_csr_bridge
	import soc_bus_pkg::*;
(
	input  logic                  sys_clk,
	input  logic                  sys_rst,
	// Wishbone slave side
	input  logic [WB_ADDR_W-1:0]  wb_adr_i,
	input  logic [WB_DATA_W-1:0]  wb_dat_i,
	input  logic                  wb_we_i,
	input  logic                  wb_cyc_i,
	input  logic                  wb_stb_i,
	output logic [WB_DATA_W-1:0]  wb_dat_o,
	output logic                  wb_ack_o,
	// CSR master side
	output logic [CSR_ADDR_W-1:0] csr_a,
	output logic                  csr_we,
	output logic [WB_DATA_W-1:0]  csr_dw,
	input  logic [WB_DATA_W-1:0]  csr_di
);

	logic [BRG_STATE_W-1:0] state;
	logic [WB_WAIT_W-1:0]   wait_cnt;
	logic                   wb_req;
	logic                   start;
	logic                   wait_done;

	assign wb_req = wb_cyc_i & wb_stb_i;
	// New access accepted only from idle
	assign start = (state == BRG_IDLE) & wb_req;
	// Read data from the banks is valid on this edge
	assign wait_done = (state == BRG_WAIT) & (wait_cnt == '0);

	// --------------------------------------------------------------------
	// FSM
	// --------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state    <= BRG_IDLE;
			wait_cnt <= '0;
			csr_a    <= '0;
			csr_we   <= 1'b0;
			wb_ack_o <= 1'b0;
		end else begin
			// CSR address and write only live for the strobe cycle
			csr_a    <= '0;
			csr_we   <= 1'b0;
			wb_ack_o <= 1'b0;
			case (state)
				BRG_IDLE: begin
					if (start) begin
						csr_a    <= wb_adr_i[CSR_ADDR_MSB:CSR_ADDR_LSB];
						csr_we   <= wb_we_i;
						wait_cnt <= WB_WAIT_W'(WB_WAIT_CYCLES - 1);
						state    <= BRG_STROBE;
					end
				end
				// Banks register their read data on the next edge
				BRG_STROBE: state <= BRG_WAIT;
				BRG_WAIT: begin
					if (wait_done) begin
						wb_ack_o <= 1'b1;
						state    <= BRG_ACK;
					end else begin
						wait_cnt <= wait_cnt - 1'b1;
					end
				end
				// Master drops stb here and one idle cycle follows
				BRG_ACK: state <= BRG_IDLE;
				default: state <= BRG_IDLE;
			endcase
		end
	end

	// --------------------------------------------------------------------
	// Data path
	// --------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (start) begin
			csr_dw <= wb_dat_i;
		end
		// Held for the master during ack
		if (wait_done) begin
			wb_dat_o <= csr_di;
		end
	end

endmodule

`default_nettype wire

//--- csr_timer.sv
// Timer bank with control, compare and counter registers on the CSR bus
`timescale 1ns/100ps
`default_nettype none

module csr_timer
	import soc_bus_pkg::*;
	import soc_periph_pkg::*;
#(
	parameter int unsigned BANK_ID = 0
) (
	input  logic                  sys_clk,
	input  logic                  sys_rst,
	input  logic [CSR_ADDR_W-1:0] csr_a,
	input  logic                  csr_we,
	input  logic [WB_DATA_W-1:0]  csr_dw,
	output logic [WB_DATA_W-1:0]  csr_do,
	output logic                  irq
);

	logic                 bank_sel;
	logic [CSR_REG_W-1:0] reg_idx;
	logic                 ctrl_en;
	logic                 ctrl_ar;
	logic [WB_DATA_W-1:0] compare;
	logic [WB_DATA_W-1:0] counter;
	logic                 match;
	logic                 wr_ctrl;
	logic                 wr_compare;
	logic                 wr_counter;
	logic [WB_DATA_W-1:0] rd_data;

	// --------------------------------------------------------------------
	// Address decode
	// --------------------------------------------------------------------
	assign bank_sel = (csr_a[CSR_BANK_MSB:CSR_BANK_LSB] == CSR_BANK_W'(BANK_ID));
	assign reg_idx  = csr_a[CSR_REG_MSB:CSR_REG_LSB];

	assign wr_ctrl    = bank_sel & csr_we & (reg_idx == CSR_REG_W'(TIMER_REG_CTRL));
	assign wr_compare = bank_sel & csr_we & (reg_idx == CSR_REG_W'(TIMER_REG_COMPARE));
	assign wr_counter = bank_sel & csr_we & (reg_idx == CSR_REG_W'(TIMER_REG_COUNTER));

	// Irq is high for exactly the match cycle
	assign match = ctrl_en & (counter == compare);
	assign irq   = match;

	// --------------------------------------------------------------------
	// Counter and control
	// --------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			ctrl_en <= 1'b0;
			ctrl_ar <= 1'b0;
			counter <= '0;
		end else begin
			if (match) begin
				// Restart from zero, or stop and keep the compare value
				if (ctrl_ar) begin
					counter <= '0;
				end else begin
					ctrl_en <= 1'b0;
				end
			end else if (ctrl_en) begin
				counter <= counter + 1'b1;
			end
			// Software writes win over the running timer
			if (wr_ctrl) begin
				ctrl_en <= csr_dw[TIMER_CTRL_EN_BIT];
				ctrl_ar <= csr_dw[TIMER_CTRL_AR_BIT];
			end
			if (wr_counter) begin
				counter <= csr_dw;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (wr_compare) begin
			compare <= csr_dw;
		end
	end

	// --------------------------------------------------------------------
	// Read back
	// --------------------------------------------------------------------
	always_comb begin
		rd_data = '0;
		case (reg_idx)
			CSR_REG_W'(TIMER_REG_CTRL): begin
				rd_data[TIMER_CTRL_EN_BIT] = ctrl_en;
				rd_data[TIMER_CTRL_AR_BIT] = ctrl_ar;
			end
			CSR_REG_W'(TIMER_REG_COMPARE): rd_data = compare;
			CSR_REG_W'(TIMER_REG_COUNTER): rd_data = counter;
			default: rd_data = '0;
		endcase
	end

	// Zero when another bank is addressed so the OR-combine works
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			csr_do <= '0;
		end else begin
			csr_do <= bank_sel ? rd_data : '0;
		end
	end

endmodule

`default_nettype wire

//--- csr_irq_ctrl.sv
// Interrupt pending and mask bank, plus the OR-combine of CSR read data
`timescale 1ns/100ps
`default_nettype none

module csr_irq_ctrl
	import soc_bus_pkg::*;
	import soc_periph_pkg::*;
(
	input  logic                                  sys_clk,
	input  logic                                  sys_rst,
	input  logic [CSR_ADDR_W-1:0]                 csr_a,
	input  logic                                  csr_we,
	input  logic [WB_DATA_W-1:0]                  csr_dw,
	input  logic [NUM_TIMERS-1:0][WB_DATA_W-1:0]  timer_do,
	input  logic [NUM_TIMERS-1:0]                 timer_irq,
	output logic [WB_DATA_W-1:0]                  csr_di,
	output logic                                  irq_o
);

	logic                  bank_sel;
	logic [CSR_REG_W-1:0]  reg_idx;
	logic                  wr_pending;
	logic                  wr_mask;
	logic [NUM_TIMERS-1:0] pending;
	logic [NUM_TIMERS-1:0] mask;
	logic [NUM_TIMERS-1:0] pend_clr;
	logic [WB_DATA_W-1:0]  rd_data;
	logic [WB_DATA_W-1:0]  irq_do;

	assign bank_sel   = (csr_a[CSR_BANK_MSB:CSR_BANK_LSB] == CSR_BANK_W'(IRQ_BANK));
	assign reg_idx    = csr_a[CSR_REG_MSB:CSR_REG_LSB];
	assign wr_pending = bank_sel & csr_we & (reg_idx == CSR_REG_W'(IRQ_REG_PENDING));
	assign wr_mask    = bank_sel & csr_we & (reg_idx == CSR_REG_W'(IRQ_REG_MASK));

	// Write one to clear
	assign pend_clr = wr_pending ? csr_dw[NUM_TIMERS-1:0] : '0;

	always_comb begin
		rd_data = '0;
		if (reg_idx == CSR_REG_W'(IRQ_REG_PENDING)) begin
			rd_data[NUM_TIMERS-1:0] = pending;
		end else if (reg_idx == CSR_REG_W'(IRQ_REG_MASK)) begin
			rd_data[NUM_TIMERS-1:0] = mask;
		end
	end

	// --------------------------------------------------------------------
	// Pending, mask and interrupt output
	// --------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			pending <= '0;
			mask    <= '0;
			irq_o   <= 1'b0;
			irq_do  <= '0;
		end else begin
			// A new pulse beats a clear in the same cycle
			pending <= (pending & ~pend_clr) | timer_irq;
			if (wr_mask) begin
				mask <= csr_dw[NUM_TIMERS-1:0];
			end
			irq_o  <= |(pending & mask);
			irq_do <= bank_sel ? rd_data : '0;
		end
	end

	// All banks return zero unless addressed
	always_comb begin
		csr_di = irq_do;
		for (int k = 0; k < NUM_TIMERS; k++) begin
			csr_di = csr_di | timer_do[k];
		end
	end

endmodule

`default_nettype wire

//--- csr_timer_system.sv
// Top level with reset generator, bridge, interrupt controller and timer banks
`timescale 1ns/100ps
`default_nettype none

module csr_timer_system
	import soc_bus_pkg::*;
	import soc_periph_pkg::*;
(
	input  logic                 sys_clk,
	input  logic                 trigger_reset,
	input  logic [WB_ADDR_W-1:0] wb_adr_i,
	input  logic [WB_DATA_W-1:0] wb_dat_i,
	input  logic                 wb_we_i,
	input  logic                 wb_cyc_i,
	input  logic                 wb_stb_i,
	output logic [WB_DATA_W-1:0] wb_dat_o,
	output logic                 wb_ack_o,
	output logic                 irq_o,
	output logic                 sys_rst_o
);

	logic                                 sys_rst;
	logic [CSR_ADDR_W-1:0]                csr_a;
	logic                                 csr_we;
	logic [WB_DATA_W-1:0]                 csr_dw;
	logic [WB_DATA_W-1:0]                 csr_di;
	logic [NUM_TIMERS-1:0][WB_DATA_W-1:0] timer_do;
	logic [NUM_TIMERS-1:0]                timer_irq;

	// --------------------------------------------------------------------
	// Reset and bus
	// --------------------------------------------------------------------
	reset_gen u_reset_gen (
		.sys_clk       (sys_clk),
		.trigger_reset (trigger_reset),
		.sys_rst       (sys_rst)
	);

	assign sys_rst_o = sys_rst;

	wb_csr_bridge u_bridge (
		.sys_clk  (sys_clk),
		.sys_rst  (sys_rst),
		.wb_adr_i (wb_adr_i),
		.wb_dat_i (wb_dat_i),
		.wb_we_i  (wb_we_i),
		.wb_cyc_i (wb_cyc_i),
		.wb_stb_i (wb_stb_i),
		.wb_dat_o (wb_dat_o),
		.wb_ack_o (wb_ack_o),
		.csr_a    (csr_a),
		.csr_we   (csr_we),
		.csr_dw   (csr_dw),
		.csr_di   (csr_di)
	);

	// --------------------------------------------------------------------
	// CSR banks
	// --------------------------------------------------------------------
	// Timer k answers in bank k
	for (genvar k = 0; k < NUM_TIMERS; k++) begin : g_timer
		csr_timer #(
			.BANK_ID (k)
		) u_timer (
			.sys_clk (sys_clk),
			.sys_rst (sys_rst),
			.csr_a   (csr_a),
			.csr_we  (csr_we),
			.csr_dw  (csr_dw),
			.csr_do  (timer_do[k]),
			.irq     (timer_irq[k])
		);
	end

	// Also merges the read data of every bank
	csr_irq_ctrl u_irq_ctrl (
		.sys_clk   (sys_clk),
		.sys_rst   (sys_rst),
		.csr_a     (csr_a),
		.csr_we    (csr_we),
		.csr_dw    (csr_dw),
		.timer_do  (timer_do),
		.timer_irq (timer_irq),
		.csr_di    (csr_di),
		.irq_o     (irq_o)
	);

endmodule

`default_nettype wire

//--- tb_csr_tasks.svh
// Bus tasks, compare tasks and directed test tasks for the timer system testbench
`ifndef TB_CSR_TASKS_SVH
`define TB_CSR_TASKS_SVH

// ----------------------------------------------------------------------
// Compare tasks
// ----------------------------------------------------------------------
task automatic check_data(input logic [WB_DATA_W-1:0] got, input logic [WB_DATA_W-1:0] exp,
	input string what);
	check_cnt++;
	if (got !== exp) begin
		err_cnt++;
		$display("Error at %0t: %s, got 0x%08h, expected 0x%08h", $time, what, got, exp);
	end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
	check_cnt++;
	if (got !== exp) begin
		err_cnt++;
		$display("Error at %0t: %s, got %b, expected %b", $time, what, got, exp);
	end
endtask

// Cycle counts
task automatic check_count(input int got, input int exp, input string what);
	check_cnt++;
	if (got != exp) begin
		err_cnt++;
		$display("Error at %0t: %s, got %0d cycles, expected %0d", $time, what, got, exp);
	end
endtask

task automatic report_test(input string name, input int errs_before);
	test_cnt++;
	if (err_cnt == errs_before) begin
		$display("%-12s passed", name);
	end else begin
		$display("%-12s failed with %0d errors", name, err_cnt - errs_before);
	end
endtask

// ----------------------------------------------------------------------
// Wishbone master
// ----------------------------------------------------------------------
// Bank in the upper CSR bits and the word address from byte bit 2
function automatic logic [WB_ADDR_W-1:0] csr_byte_addr(input int unsigned bank,
	input int unsigned idx);
	logic [CSR_ADDR_W-1:0] word;
	word = {CSR_BANK_W'(bank), CSR_REG_W'(idx)};
	return WB_ADDR_W'(word) << CSR_ADDR_LSB;
endfunction

// Entered right after a rising edge and left right after one
task automatic wb_access(input logic we, input int unsigned bank, input int unsigned idx,
	input logic [WB_DATA_W-1:0] wdata, output logic [WB_DATA_W-1:0] rdata);
	int n;
	wb_adr_i <= csr_byte_addr(bank, idx);
	wb_dat_i <= wdata;
	wb_we_i  <= we;
	wb_cyc_i <= 1'b1;
	wb_stb_i <= 1'b1;
	n = 0;
	do begin
		@(posedge sys_clk);
		n++;
	end while (wb_ack_o !== 1'b1 && n < ACK_TIMEOUT);
	if (wb_ack_o !== 1'b1) begin
		abort_run($sformatf("no acknowledge from bank %0d within %0d cycles", bank, n));
	end
	rdata = wb_dat_o;
	// Edge 1 samples stb and ack is seen WB_ACK_DELAY edges later
	check_count(n, WB_ACK_DELAY + 1, "ack latency");
	wb_cyc_i <= 1'b0;
	wb_stb_i <= 1'b0;
	wb_we_i  <= 1'b0;
	@(posedge sys_clk);
	check_bit(wb_ack_o, 1'b0, "ack dropped after one cycle");
endtask

task automatic wb_write(input int unsigned bank, input int unsigned idx,
	input logic [WB_DATA_W-1:0] wdata);
	logic [WB_DATA_W-1:0] unused;
	wb_access(1'b1, bank, idx, wdata, unused);
endtask

task automatic wb_read(input int unsigned bank, input int unsigned idx,
	output logic [WB_DATA_W-1:0] rdata);
	wb_access(1'b0, bank, idx, '0, rdata);
endtask

// Poll the pending register until the timer's bit shows up
task automatic wait_pending(input int unsigned t, input string what);
	logic [WB_DATA_W-1:0] rdata;
	int polls;
	rdata = '0;
	polls = 0;
	while (rdata[t] !== 1'b1 && polls < POLL_LIMIT) begin
		wb_read(IRQ_BANK, IRQ_REG_PENDING, rdata);
		polls++;
	end
	if (rdata[t] !== 1'b1) begin
		abort_run($sformatf("%s, pending bit %0d never set after %0d reads", what, t, polls));
	end
endtask

// ----------------------------------------------------------------------
// Directed tests
// ----------------------------------------------------------------------
task automatic test_reset();
	int errs_before;
	int n;
	logic [WB_DATA_W-1:0] rdata;
	errs_before = err_cnt;
	trigger_reset <= 1'b1;
	// Registered reset shows from the second edge
	for (int c = 1; c <= 3; c++) begin
		@(posedge sys_clk);
		if (c > 1) begin
			check_bit(sys_rst_o, 1'b1, "sys_rst_o during trigger");
		end
	end
	trigger_reset <= 1'b0;
	// First edge with the trigger sampled low
	@(posedge sys_clk);
	n = 0;
	while (sys_rst_o !== 1'b0 && n < RST_TIMEOUT) begin
		@(posedge sys_clk);
		n++;
	end
	if (sys_rst_o !== 1'b0) begin
		abort_run("system reset was never released");
	end
	// Falls on edge RST_HOLD_CYCLES and is read one edge later
	check_count(n, RST_HOLD_CYCLES + 1, "reset release");
	check_bit(irq_o, 1'b0, "irq_o after reset");
	check_bit(wb_ack_o, 1'b0, "wb_ack_o after reset");
	for (int k = 0; k < NUM_TIMERS; k++) begin
		wb_read(k, TIMER_REG_CTRL, rdata);
		check_data(rdata, '0, $sformatf("timer %0d control after reset", k));
	end
	wb_read(IRQ_BANK, IRQ_REG_PENDING, rdata);
	check_data(rdata, '0, "pending after reset");
	wb_read(IRQ_BANK, IRQ_REG_MASK, rdata);
	check_data(rdata, '0, "mask after reset");
	report_test("reset", errs_before);
endtask

task automatic test_registers();
	int errs_before;
	logic [WB_DATA_W-1:0] cmp_val [NUM_TIMERS];
	logic [WB_DATA_W-1:0] rdata;
	errs_before = err_cnt;
	for (int k = 0; k < NUM_TIMERS; k++) begin
		cmp_val[k] = lfsr_bits(WB_DATA_W);
		wb_write(k, TIMER_REG_COMPARE, cmp_val[k]);
	end
	for (int k = 0; k < NUM_TIMERS; k++) begin
		wb_read(k, TIMER_REG_COMPARE, rdata);
		check_data(rdata, cmp_val[k], $sformatf("timer %0d compare", k));
	end
	// Unused banks up to the last one
	for (int b = IRQ_BANK + 1; b < 2 ** CSR_BANK_W; b += 13) begin
		for (int r = 0; r < 3; r++) begin
			wb_read(b, r, rdata);
			check_data(rdata, '0, $sformatf("empty bank %0d register %0d", b, r));
		end
	end
	report_test("registers", errs_before);
endtask

task automatic test_oneshot();
	int errs_before;
	logic [WB_DATA_W-1:0] cmp;
	logic [WB_DATA_W-1:0] rdata;
	errs_before = err_cnt;
	cmp = 6 + lfsr_bits(3);
	wb_write(ONESHOT_TIMER, TIMER_REG_COMPARE, cmp);
	wb_write(ONESHOT_TIMER, TIMER_REG_COUNTER, '0);
	wb_write(ONESHOT_TIMER, TIMER_REG_CTRL, WB_DATA_W'(1) << TIMER_CTRL_EN_BIT);
	wait_pending(ONESHOT_TIMER, "one-shot");
	// Stopped on the match with the count held
	wb_read(ONESHOT_TIMER, TIMER_REG_CTRL, rdata);
	check_data(rdata, '0, "one-shot control after match");
	wb_read(ONESHOT_TIMER, TIMER_REG_COUNTER, rdata);
	check_data(rdata, cmp, "one-shot counter after match");
	wb_read(IRQ_BANK, IRQ_REG_PENDING, rdata);
	check_data(rdata, WB_DATA_W'(1) << ONESHOT_TIMER, "pending after one-shot");
	report_test("one-shot", errs_before);
endtask

task automatic test_masking();
	int errs_before;
	int n;
	logic [WB_DATA_W-1:0] rdata;
	errs_before = err_cnt;
	// One-shot bit still pending with the mask clear
	for (int c = 0; c < 4; c++) begin
		@(posedge sys_clk);
		check_bit(irq_o, 1'b0, "irq_o with mask clear");
	end
	wb_write(IRQ_BANK, IRQ_REG_MASK, WB_DATA_W'(1) << ONESHOT_TIMER);
	n = 0;
	while (irq_o !== 1'b1 && n < IRQ_WAIT) begin
		@(posedge sys_clk);
		n++;
	end
	check_bit(irq_o, 1'b1, "irq_o after setting mask");
	// Write one to clear
	wb_write(IRQ_BANK, IRQ_REG_PENDING, WB_DATA_W'(1) << ONESHOT_TIMER);
	n = 0;
	while (irq_o !== 1'b0 && n < IRQ_WAIT) begin
		@(posedge sys_clk);
		n++;
	end
	check_bit(irq_o, 1'b0, "irq_o after clearing pending");
	wb_read(IRQ_BANK, IRQ_REG_PENDING, rdata);
	check_data(rdata, '0, "pending after clear");
	wb_write(IRQ_BANK, IRQ_REG_MASK, '0);
	report_test("masking", errs_before);
endtask

task automatic test_autorestart();
	int errs_before;
	logic [WB_DATA_W-1:0] cmp;
	logic [WB_DATA_W-1:0] ctrl_val;
	logic [WB_DATA_W-1:0] pend_bit;
	logic [WB_DATA_W-1:0] rdata;
	errs_before = err_cnt;
	cmp      = 20 + lfsr_bits(4);
	ctrl_val = (WB_DATA_W'(1) << TIMER_CTRL_EN_BIT) | (WB_DATA_W'(1) << TIMER_CTRL_AR_BIT);
	pend_bit = WB_DATA_W'(1) << AUTO_TIMER;
	wb_write(AUTO_TIMER, TIMER_REG_COMPARE, cmp);
	wb_write(AUTO_TIMER, TIMER_REG_COUNTER, '0);
	wb_write(AUTO_TIMER, TIMER_REG_CTRL, ctrl_val);
	// Second round shows the bit coming back after the clear
	for (int round = 0; round < 2; round++) begin
		wait_pending(AUTO_TIMER, $sformatf("autorestart round %0d", round));
		wb_write(IRQ_BANK, IRQ_REG_PENDING, pend_bit);
	end
	wb_read(AUTO_TIMER, TIMER_REG_CTRL, rdata);
	check_data(rdata, ctrl_val, "autorestart control");
	for (int i = 0; i < 6; i++) begin
		wb_read(AUTO_TIMER, TIMER_REG_COUNTER, rdata);
		check_bit(rdata <= cmp, 1'b1,
			$sformatf("counter 0x%0h within compare 0x%0h", rdata, cmp));
	end
	// Stop it and drop the pending bit
	wb_write(AUTO_TIMER, TIMER_REG_CTRL, '0);
	wb_write(IRQ_BANK, IRQ_REG_PENDING, pend_bit);
	report_test("autorestart", errs_before);
endtask

`endif

//--- tb_csr_timer_system.sv
// Testbench top with clock, reset stimulus, LFSR, DUT and the directed test sequence
`timescale 1ns/100ps
`default_nettype none

module tb_csr_timer_system
	import soc_bus_pkg::*;
	import soc_periph_pkg::*;
();

	// --------------------------------------------------------------------
	// Constants
	// --------------------------------------------------------------------
	localparam int unsigned CLK_HALF = 2;
	localparam logic [15:0] LFSR_SEED = 16'd59921;
	// Edge limits of the wait loops
	localparam int unsigned ACK_TIMEOUT = 4 * WB_ACK_DELAY + 4;
	localparam int unsigned RST_TIMEOUT = 4 * RST_HOLD_CYCLES;
	localparam int unsigned POLL_LIMIT = 40;
	localparam int unsigned IRQ_WAIT = 2;
	// Timers picked for the one-shot and autorestart runs
	localparam int unsigned ONESHOT_TIMER = 1;
	localparam int unsigned AUTO_TIMER = 2;

	logic                 sys_clk;
	logic                 trigger_reset;
	logic [WB_ADDR_W-1:0] wb_adr_i;
	logic [WB_DATA_W-1:0] wb_dat_i;
	logic                 wb_we_i;
	logic                 wb_cyc_i;
	logic                 wb_stb_i;
	logic [WB_DATA_W-1:0] wb_dat_o;
	logic                 wb_ack_o;
	logic                 irq_o;
	logic                 sys_rst_o;

	logic [15:0] lfsr_state;
	int          test_cnt;
	int          check_cnt;
	int          err_cnt;
	event        run_stopped;

	csr_timer_system DUT (
		.sys_clk       (sys_clk),
		.trigger_reset (trigger_reset),
		.wb_adr_i      (wb_adr_i),
		.wb_dat_i      (wb_dat_i),
		.wb_we_i       (wb_we_i),
		.wb_cyc_i      (wb_cyc_i),
		.wb_stb_i      (wb_stb_i),
		.wb_dat_o      (wb_dat_o),
		.wb_ack_o      (wb_ack_o),
		.irq_o         (irq_o),
		.sys_rst_o     (sys_rst_o)
	);

	// 4 ns clock
	initial begin
		sys_clk = 1'b0;
		forever #CLK_HALF sys_clk = ~sys_clk;
	end

	// --------------------------------------------------------------------
	// LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
	// --------------------------------------------------------------------
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		return fb;
	endfunction

	// One step per bit
	function automatic logic [31:0] lfsr_bits(input int unsigned n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_bit()};
		end
		return v;
	endfunction

	// --------------------------------------------------------------------
	// End of run
	// --------------------------------------------------------------------
	task automatic end_run();
		$display("Tests: %0d, checks: %0d, errors: %0d", test_cnt, check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	endtask

	// Hand the stuck run over to the closing process
	task automatic abort_run(input string why);
		$display("Run stopped: %s", why);
		-> run_stopped;
		// Held here while the run closes
		@(posedge sys_clk);
	endtask

	// Closes a run whose DUT got stuck
	initial begin
		@(run_stopped);
		$display("Tests: %0d, checks: %0d, errors: %0d", test_cnt, check_cnt, err_cnt);
		$display("TEST FAILED");
		$finish;
	end

	`include "tb_csr_tasks.svh"

	// --------------------------------------------------------------------
	// Test sequence
	// --------------------------------------------------------------------
	initial begin
		trigger_reset = 1'b1;
		wb_adr_i      = '0;
		wb_dat_i      = '0;
		wb_we_i       = 1'b0;
		wb_cyc_i      = 1'b0;
		wb_stb_i      = 1'b0;
		lfsr_state    = LFSR_SEED;
		test_cnt      = 0;
		check_cnt     = 0;
		err_cnt       = 0;
		test_reset();
		test_registers();
		test_oneshot();
		test_masking();
		test_autorestart();
		end_run();
	end

endmodule

`default_nettype wire

//--- csr_timer_system.f
+incdir+.
soc_bus_pkg.sv
soc_periph_pkg.sv
reset_gen.sv
wb_csr_bridge.sv
csr_timer.sv
csr_irq_ctrl.sv
csr_timer_system.sv
tb_csr_timer_system.sv

//--- Bender.yml
package:
  name: csr_timer_system

sources:
  - files:
      - soc_bus_pkg.sv
      - soc_periph_pkg.sv
      - reset_gen.sv
      - wb_csr_bridge.sv
      - csr_timer.sv
      - csr_irq_ctrl.sv
      - csr_timer_system.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_csr_timer_system.sv
